//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = decode_tb
FILELIST = compile.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the decode stage testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf $(BUILD)

//--- compile.f
hdl/decode_pkg.sv
hdl/decode_fields_if.sv
hdl/replay_fsm.sv
hdl/instr_decoder.sv
hdl/regfile.sv
hdl/cregfile.sv
hdl/interval_timer.sv
hdl/decode_stage.sv
verif/decode_tb.sv

//--- hdl/cregfile.sv
`timescale 1ns/1ps

module cregfile (
  input  logic clk,
  input  logic rst,
  input  logic halt,
  input  decode_pkg::reg_idx_t cr_s,
  input  logic cr_we,
  input  decode_pkg::reg_idx_t target,
  input  decode_pkg::word_t write_data,
  input  logic exc_in_wb,
  input  logic rfe_in_wb,
  input  logic interrupt_in_wb,
  input  decode_pkg::word_t epc,
  input  decode_pkg::word_t efg,
  input  logic [decode_pkg::NUM_IRQ-1:0] irq_lines,
  output decode_pkg::word_t cr_d,
  output logic kmode,
  output logic [decode_pkg::PID_W-1:0] pid,
  output logic [decode_pkg::NUM_IRQ-1:0] interrupt_state
);
  import decode_pkg::*;

  localparam reg_idx_t CR_STATUS = 5'd0;
  localparam reg_idx_t CR_PID = 5'd1;
  localparam reg_idx_t CR_ENABLE = 5'd2;
  localparam reg_idx_t CR_EPC = 5'd3;
  localparam reg_idx_t CR_EFG = 5'd4;

  logic [NUM_IRQ-1:0] enable;
  logic [NUM_IRQ-1:0] pending;
  logic [NUM_IRQ-1:0] taken;
  word_t epc_q;
  word_t efg_q;

  // the line the stage reported is the highest enabled one
  assign taken = interrupt_in_wb ? (NUM_IRQ'(1) << highest_line(pending & enable)) : '0;

  always_comb begin
    case (cr_s)
      CR_STATUS: cr_d = {{(WORD_W-1){1'b0}}, kmode};
      CR_PID: cr_d = {{(WORD_W-PID_W){1'b0}}, pid};
      CR_ENABLE: cr_d = {{(WORD_W-NUM_IRQ){1'b0}}, enable};
      CR_EPC: cr_d = epc_q;
      CR_EFG: cr_d = efg_q;
      default: cr_d = '0;
    endcase
  end

  assign interrupt_state = kmode ? '0 : (pending & enable); // masked in kernel mode

  always_ff @(posedge clk) begin
    if (rst) begin
      kmode <= 1'b1;
      pid <= '0;
      enable <= '0;
      pending <= '0;
      epc_q <= '0;
      efg_q <= '0;
    end else if (!halt) begin
      pending <= (pending & ~taken) | irq_lines;
      if (cr_we) begin
        case (target)
          CR_STATUS: kmode <= write_data[0];
          CR_PID: pid <= write_data[PID_W-1:0];
          CR_ENABLE: enable <= write_data[NUM_IRQ-1:0];
          CR_EPC: epc_q <= write_data;
          CR_EFG: efg_q <= write_data;
          default: ;
        endcase
      end
      if (rfe_in_wb) kmode <= 1'b0;
      if (exc_in_wb) begin // exception entry overrides everything
        epc_q <= epc;
        efg_q <= efg;
        kmode <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/decode_fields_if.sv
`timescale 1ns/1ps

interface decode_fields_if;
  import decode_pkg::*;

  opcode_t opcode;
  logic [4:0] alu_op;
  logic [4:0] branch_code;
  logic [4:0] priv_type;
  logic [1:0] crmov_mode;
  reg_idx_t s_1;
  reg_idx_t s_2;
  reg_idx_t cr_s;
  reg_idx_t tgt_1;
  reg_idx_t tgt_2;
  word_t imm;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_post_inc;
  logic tgts_cr;
  logic tlb_we;
  logic tlbc;
  exc_t fault_exc; // decoder-side only, no irq or earlier-stage codes

  modport producer (
    output opcode, alu_op, branch_code, priv_type, crmov_mode, s_1, s_2, cr_s,
    output tgt_1, tgt_2, imm, is_load, is_store, is_branch, is_post_inc, tgts_cr,
    output tlb_we, tlbc, fault_exc
  );

  modport consumer (
    input opcode, alu_op, branch_code, priv_type, crmov_mode, s_1, s_2, cr_s,
    input tgt_1, tgt_2, imm, is_load, is_store, is_branch, is_post_inc, tgts_cr,
    input tlb_we, tlbc, fault_exc
  );

endinterface

//--- hdl/decode_pkg.sv
package decode_pkg;

  localparam int REG_IDX_W = 5;
  localparam int WORD_W = 32;
  localparam int OPCODE_W = 5;
  localparam int EXC_W = 8;
  localparam int PID_W = 12;
  localparam int NUM_IRQ = 16;
  localparam int IRQ_IDX_W = $clog2(NUM_IRQ);

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [EXC_W-1:0] exc_t;

  localparam opcode_t OP_ALU_REG = 5'd0;
  localparam opcode_t OP_ALU_IMM = 5'd1;
  localparam opcode_t OP_LUI = 5'd2;
  localparam opcode_t OP_MEM_FIRST = 5'd3;
  localparam opcode_t OP_MEM_LAST = 5'd11;
  localparam opcode_t OP_BR_FIRST = 5'd12; // pc-relative, the rest are register-indirect
  localparam opcode_t OP_BR_LAST = 5'd14;
  localparam opcode_t OP_SYSCALL = 5'd15;
  localparam opcode_t OP_PRIV = 5'd31;

  localparam exc_t EXC_NONE = 8'h00;
  localparam exc_t EXC_SYSCALL = 8'h01; // only legal syscall code
  localparam exc_t EXC_BAD_INSTR = 8'h80;
  localparam exc_t EXC_BAD_PRIV = 8'h81;
  localparam exc_t EXC_IRQ_BASE = 8'hF0; // plus line number

  localparam logic [4:0] ALU_OP_MAX = 5'd18;
  localparam logic [4:0] BRANCH_CODE_MAX = 5'd18;
  localparam logic [4:0] PRIV_TYPE_MAX = 5'd3;

  typedef struct packed {
    opcode_t opcode;
    reg_idx_t r_a;
    reg_idx_t r_b;
    logic [4:0] op_sel;
    logic [11:0] low;
  } std_fmt_t;

  typedef struct packed {
    opcode_t opcode;
    logic [4:0] branch_code;
    logic [11:0] mid;
    reg_idx_t r_a;
    reg_idx_t r_b;
  } br_fmt_t;

  typedef union packed {
    std_fmt_t std;
    br_fmt_t br;
  } instr_u;

  // highest set line wins
  function automatic logic [IRQ_IDX_W-1:0] highest_line(input logic [NUM_IRQ-1:0] lines);
    logic [IRQ_IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (lines[i]) idx = IRQ_IDX_W'(i);
    end
    return idx;
  endfunction

endpackage

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int TIMER_PERIOD = 64
) (
  input  logic clk,
  input  logic rst,
  input  logic halt,
  input  logic stall,
  input  logic flush,
  input  decode_pkg::word_t mem_word,
  input  logic bubble_in,
  input  decode_pkg::word_t pc_in,
  input  decode_pkg::exc_t exc_in,
  input  decode_pkg::exc_t tlb_exc_in,
  input  logic we1,
  input  decode_pkg::reg_idx_t target_1,
  input  decode_pkg::word_t write_data_1,
  input  logic we2,
  input  decode_pkg::reg_idx_t target_2,
  input  decode_pkg::word_t write_data_2,
  input  logic cr_we,
  input  logic exc_in_wb,
  input  logic rfe_in_wb,
  input  logic interrupt_in_wb,
  input  decode_pkg::word_t epc,
  input  decode_pkg::word_t efg,
  input  logic [decode_pkg::NUM_IRQ-2:0] irq,
  output decode_pkg::word_t d_1,
  output decode_pkg::word_t d_2,
  output decode_pkg::word_t cr_d,
  output decode_pkg::word_t pc_out,
  output decode_pkg::opcode_t opcode_out,
  output decode_pkg::reg_idx_t s_1_out,
  output decode_pkg::reg_idx_t s_2_out,
  output decode_pkg::reg_idx_t cr_s_out,
  output decode_pkg::reg_idx_t tgt_out_1,
  output decode_pkg::reg_idx_t tgt_out_2,
  output logic [4:0] alu_op_out,
  output decode_pkg::word_t imm_out,
  output logic [4:0] branch_code_out,
  output logic bubble_out,
  output logic is_load_out,
  output logic is_store_out,
  output logic is_branch_out,
  output logic is_post_inc_out,
  output logic tgts_cr_out,
  output logic [4:0] priv_type_out,
  output logic [1:0] crmov_mode_out,
  output logic tlb_we,
  output logic tlbc,
  output decode_pkg::exc_t exc_out,
  output logic kmode,
  output logic [decode_pkg::PID_W-1:0] pid
);
  import decode_pkg::*;

  decode_fields_if fields ();

  instr_u instr;
  logic tick;
  logic [NUM_IRQ-1:0] interrupt_state;
  logic no_tgt;
  exc_t exc_next;

  replay_fsm replay_fsm_i (
    .clk, .rst, .halt, .stall, .mem_word, .instr
  );

  instr_decoder instr_decoder_i (
    .instr, .bubble_in, .kmode, .tlb_exc_in, .fields(fields)
  );

  // halt freezes writeback writes as well as reads
  regfile regfile_i (
    .clk, .rst,
    .stall(stall || halt),
    .s_1(fields.s_1),
    .s_2(fields.s_2),
    .we1(we1 && !halt), .target_1, .write_data_1,
    .we2(we2 && !halt), .target_2, .write_data_2,
    .d_1, .d_2
  );

  // read index comes from the stage register, so cr_d lines up with d_1/d_2
  cregfile cregfile_i (
    .clk, .rst, .halt,
    .cr_s(cr_s_out),
    .cr_we, .target(target_1), .write_data(write_data_1),
    .exc_in_wb, .rfe_in_wb, .interrupt_in_wb,
    .epc, .efg,
    .irq_lines({irq, tick}),
    .cr_d, .kmode, .pid, .interrupt_state
  );

  interval_timer #(
    .TIMER_PERIOD(TIMER_PERIOD)
  ) interval_timer_i (
    .clk, .rst, .halt, .tick
  );

  assign no_tgt = flush || bubble_in;

  // interrupt, then earlier stage, then our own fault
  always_comb begin
    if (interrupt_state != '0) exc_next = EXC_IRQ_BASE + highest_line(interrupt_state);
    else if (exc_in != EXC_NONE) exc_next = exc_in;
    else exc_next = fields.fault_exc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bubble_out <= 1'b1;
      tgt_out_1 <= '0;
      tgt_out_2 <= '0;
      exc_out <= EXC_NONE;
      tlb_we <= 1'b0;
      tlbc <= 1'b0;
      cr_s_out <= '0;
    end else if (!halt && !stall) begin
      pc_out <= pc_in;
      opcode_out <= fields.opcode;
      s_1_out <= fields.s_1;
      s_2_out <= fields.s_2;
      cr_s_out <= fields.cr_s;
      tgt_out_1 <= no_tgt ? '0 : fields.tgt_1;
      tgt_out_2 <= no_tgt ? '0 : fields.tgt_2;
      alu_op_out <= fields.alu_op;
      imm_out <= fields.imm;
      branch_code_out <= fields.branch_code;
      bubble_out <= flush || bubble_in;
      is_load_out <= fields.is_load;
      is_store_out <= fields.is_store;
      is_branch_out <= fields.is_branch;
      is_post_inc_out <= fields.is_post_inc;
      tgts_cr_out <= fields.tgts_cr;
      priv_type_out <= fields.priv_type;
      crmov_mode_out <= fields.crmov_mode;
      tlb_we <= fields.tlb_we;
      tlbc <= fields.tlbc;
      exc_out <= exc_next;
    end
  end

  a_tlb_exclusive: assert property (@(posedge clk) disable iff (rst) !(tlb_we && tlbc))
    else $error("tlb_we and tlbc both set");

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  decode_pkg::instr_u instr,
  input  logic bubble_in,
  input  logic kmode,
  input  decode_pkg::exc_t tlb_exc_in,
  decode_fields_if.producer fields
);
  import decode_pkg::*;

  opcode_t opcode;
  reg_idx_t r_a;
  reg_idx_t r_b;
  reg_idx_t r_c;
  logic [11:0] low;
  logic [4:0] alu_op;
  logic [4:0] branch_code;
  logic [4:0] priv_type;
  logic [1:0] crmov_mode;
  logic [1:0] inc_type;
  logic [1:0] mem_shift;
  logic [4:0] alu_shift;
  logic [21:0] upper;
  logic [21:0] br_off;
  logic is_br_ind;
  logic is_alu, is_mem, is_branch, is_syscall, is_priv;
  logic is_bitwise, is_shift, is_arith;
  logic is_abs_mem, is_disp16, is_disp21;
  logic load_bit, is_load, is_store;
  logic drops_r_b, bad_instr, bad_priv;
  word_t imm;
  exc_t fault_exc;

  assign opcode = instr.std.opcode;
  assign is_br_ind = (opcode > OP_BR_FIRST) && (opcode <= OP_BR_LAST);

  // indirect branches keep their registers in the low bits
  assign r_a = is_br_ind ? instr.br.r_a : instr.std.r_a;
  assign r_b = is_br_ind ? instr.br.r_b : instr.std.r_b;
  assign low = instr.std.low;
  assign r_c = low[4:0];
  assign alu_op = (opcode == OP_ALU_REG) ? low[9:5] : instr.std.op_sel;
  assign branch_code = instr.br.branch_code;
  assign priv_type = instr.std.op_sel;
  assign crmov_mode = low[11:10];
  assign inc_type = instr.std.op_sel[3:2]; // 0 offset, 1 pre, 2 post
  assign mem_shift = instr.std.op_sel[1:0];
  assign alu_shift = {low[9:8], 3'b000}; // byte lane
  assign upper = {instr.std.r_b, instr.std.op_sel, low};
  assign br_off = {instr.br.mid, instr.br.r_a, instr.br.r_b};

  assign is_alu = (opcode == OP_ALU_REG) || (opcode == OP_ALU_IMM);
  assign is_mem = (opcode >= OP_MEM_FIRST) && (opcode <= OP_MEM_LAST);
  assign is_branch = (opcode >= OP_BR_FIRST) && (opcode <= OP_BR_LAST);
  assign is_syscall = opcode == OP_SYSCALL;
  assign is_priv = opcode == OP_PRIV;

  assign is_bitwise = alu_op <= 5'd6;
  assign is_shift = (alu_op >= 5'd7) && (alu_op <= 5'd13);
  assign is_arith = (alu_op >= 5'd14) && (alu_op <= ALU_OP_MAX);

  // memory opcodes come in groups of three addressing forms
  always_comb begin
    is_abs_mem = 1'b0;
    is_disp16 = 1'b0;
    is_disp21 = 1'b0;
    case (opcode)
      5'd3, 5'd6, 5'd9: is_abs_mem = 1'b1;
      5'd4, 5'd7, 5'd10: is_disp16 = 1'b1;
      5'd5, 5'd8, 5'd11: is_disp21 = 1'b1;
      default: ;
    endcase
  end

  assign load_bit = is_disp21 ? instr.std.r_b[4] : instr.std.op_sel[4];
  assign is_load = is_mem && load_bit;
  assign is_store = is_mem && !load_bit;

  assign drops_r_b = (opcode == OP_LUI) || is_disp21 || (opcode == OP_BR_FIRST) ||
                     is_syscall || (is_alu && alu_op == 5'd6);

  always_comb begin
    if (opcode == OP_ALU_IMM && is_bitwise) imm = {24'b0, low[7:0]} << alu_shift;
    else if (opcode == OP_ALU_IMM && is_shift) imm = {27'b0, low[4:0]};
    else if (opcode == OP_ALU_IMM && is_arith) imm = {{20{low[11]}}, low};
    else if (opcode == OP_LUI) imm = {upper, 10'b0};
    else if (opcode == OP_BR_FIRST) imm = {{10{br_off[21]}}, br_off};
    else if (is_abs_mem) imm = {{20{low[11]}}, low} << mem_shift;
    else if (is_disp16) imm = {{16{upper[15]}}, upper[15:0]};
    else if (is_disp21) imm = {{11{upper[20]}}, upper[20:0]};
    else imm = '0;
  end

  assign bad_instr = ((opcode > OP_SYSCALL) && (opcode < OP_PRIV)) ||
                     (is_alu && alu_op > ALU_OP_MAX) ||
                     (is_branch && branch_code > BRANCH_CODE_MAX) ||
                     (is_syscall && low[7:0] != EXC_SYSCALL) ||
                     (is_priv && priv_type > PRIV_TYPE_MAX);
  assign bad_priv = is_priv && !kmode;

  always_comb begin
    if (bubble_in) fault_exc = EXC_NONE;
    else if (bad_instr) fault_exc = EXC_BAD_INSTR;
    else if (bad_priv) fault_exc = EXC_BAD_PRIV;
    else if (is_syscall) fault_exc = low[7:0];
    else fault_exc = tlb_exc_in; // zero when the tlb is happy
  end

  assign fields.opcode = opcode;
  assign fields.alu_op = alu_op;
  assign fields.branch_code = branch_code;
  assign fields.priv_type = priv_type;
  assign fields.crmov_mode = crmov_mode;
  assign fields.s_1 = drops_r_b ? '0 : r_b;
  assign fields.s_2 = (is_store || is_priv) ? r_a : ((opcode == OP_ALU_REG) ? r_c : '0);
  assign fields.cr_s = r_b;
  assign fields.tgt_1 = is_store ? '0 : r_a; // stores read r_a
  assign fields.tgt_2 = (!is_abs_mem || inc_type == 2'd0) ? '0 : r_b; // base writeback
  assign fields.imm = imm;
  assign fields.is_load = is_load;
  assign fields.is_store = is_store;
  assign fields.is_branch = is_branch;
  assign fields.is_post_inc = is_abs_mem && inc_type == 2'd2;
  assign fields.tgts_cr = is_priv && priv_type == 5'd1 &&
                          (crmov_mode == 2'd0 || crmov_mode == 2'd2);
  assign fields.tlb_we = is_priv && priv_type == 5'd0 && crmov_mode == 2'd1;
  assign fields.tlbc = is_priv && priv_type == 5'd0 && crmov_mode == 2'd2;
  assign fields.fault_exc = fault_exc;

endmodule

//--- hdl/interval_timer.sv
`timescale 1ns/1ps

module interval_timer #(
  parameter int TIMER_PERIOD = 64
) (
  input  logic clk,
  input  logic rst,
  input  logic halt,
  output logic tick
);

  localparam int CNT_W = $clog2(TIMER_PERIOD + 1);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TIMER_PERIOD - 1);

  logic [CNT_W-1:0] count;

  assign tick = count == '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= RELOAD;
    end else if (!halt) begin
      count <= tick ? RELOAD : count - 1'b1; // period counts enabled cycles only
    end
  end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  decode_pkg::reg_idx_t s_1,
  input  decode_pkg::reg_idx_t s_2,
  input  logic we1,
  input  decode_pkg::reg_idx_t target_1,
  input  decode_pkg::word_t write_data_1,
  input  logic we2,
  input  decode_pkg::reg_idx_t target_2,
  input  decode_pkg::word_t write_data_2,
  output decode_pkg::word_t d_1,
  output decode_pkg::word_t d_2
);
  import decode_pkg::*;

  word_t regs [2**REG_IDX_W];
  reg_idx_t s_1_q;

  // sees this edge's writes, port 2 first
  function automatic word_t read_new(input reg_idx_t idx);
    if (idx == '0) return '0;
    if (we2 && target_2 == idx) return write_data_2;
    if (we1 && target_1 == idx) return write_data_1;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_IDX_W; i++) regs[i] <= '0;
      d_1 <= '0;
      d_2 <= '0;
      s_1_q <= '0;
    end else begin
      if (we1 && target_1 != '0) regs[target_1] <= write_data_1;
      if (we2 && target_2 != '0) regs[target_2] <= write_data_2; // later one wins
      if (!stall) begin
        d_1 <= read_new(s_1);
        d_2 <= read_new(s_2);
        s_1_q <= s_1;
      end
    end
  end

  a_r0_reads_zero: assert property (@(posedge clk) disable iff (rst)
    s_1_q == '0 |-> d_1 == '0)
    else $error("regfile d_1 nonzero for register 0");

endmodule

//--- hdl/replay_fsm.sv
`timescale 1ns/1ps

module replay_fsm (
  input  logic clk,
  input  logic rst,
  input  logic halt,
  input  logic stall,
  input  decode_pkg::word_t mem_word,
  output decode_pkg::instr_u instr
);
  import decode_pkg::*;

  localparam logic [1:0] LIVE = 2'd0;
  localparam logic [1:0] HELD = 2'd1;    // last edge was stalled
  localparam logic [1:0] REPLAY1 = 2'd2;
  localparam logic [1:0] REPLAY2 = 2'd3;

  logic [1:0] state;
  logic [1:0] state_next;
  word_t held_word;

  always_comb begin
    if (stall) begin
      state_next = HELD;
    end else begin
      case (state)
        HELD: state_next = REPLAY1;
        REPLAY1: state_next = REPLAY2;
        default: state_next = LIVE;
      endcase
    end
  end

  // fetch memory runs ahead of us, so keep a one-word copy
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LIVE;
    end else if (!halt) begin
      state <= state_next;
      if (!(stall && state == HELD)) held_word <= mem_word; // freeze only on a continuing stall
    end
  end

  assign instr = (state == LIVE) ? mem_word : held_word;

  a_replay_order: assert property (@(posedge clk) disable iff (rst)
    (state == REPLAY2) && !$past(halt) |-> $past(state) == REPLAY1)
    else $error("replay_fsm reached REPLAY2 without REPLAY1");

endmodule

//--- verif/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

  localparam int PERIOD = 64;

  typedef struct packed {
    logic [4:0] opcode;
    logic [4:0] alu_op;
    logic [4:0] branch_code;
    logic [4:0] priv_type;
    logic [1:0] crmov_mode;
    logic [4:0] s_1;
    logic [4:0] s_2;
    logic [4:0] cr_s;
    logic [4:0] tgt_1;
    logic [4:0] tgt_2;
    logic [31:0] imm;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_post_inc;
    logic tgts_cr;
    logic tlb_we;
    logic tlbc;
    logic [7:0] fault;
  } fields_t;

  logic clk;
  logic rst;
  logic halt;
  logic stall;
  logic flush;
  logic bubble_in;
  logic [31:0] mem_word;
  logic [31:0] pc_in;
  logic [7:0] exc_in;
  logic [7:0] tlb_exc_in;
  logic we1;
  logic we2;
  logic cr_we;
  logic [4:0] target_1;
  logic [4:0] target_2;
  logic [31:0] write_data_1;
  logic [31:0] write_data_2;
  logic exc_in_wb;
  logic rfe_in_wb;
  logic interrupt_in_wb;
  logic [31:0] epc;
  logic [31:0] efg;
  logic [14:0] irq;

  logic [31:0] d_1;
  logic [31:0] d_2;
  logic [31:0] cr_d;
  logic [31:0] pc_out;
  logic [4:0] opcode_out;
  logic [4:0] s_1_out;
  logic [4:0] s_2_out;
  logic [4:0] cr_s_out;
  logic [4:0] tgt_out_1;
  logic [4:0] tgt_out_2;
  logic [4:0] alu_op_out;
  logic [31:0] imm_out;
  logic [4:0] branch_code_out;
  logic bubble_out;
  logic is_load_out;
  logic is_store_out;
  logic is_branch_out;
  logic is_post_inc_out;
  logic tgts_cr_out;
  logic [4:0] priv_type_out;
  logic [1:0] crmov_mode_out;
  logic tlb_we;
  logic tlbc;
  logic [7:0] exc_out;
  logic kmode;
  logic [11:0] pid;

  // reference model state
  logic [31:0] m_regs [32];
  logic m_kmode;
  logic [11:0] m_pid;
  logic [15:0] m_enable;
  logic [15:0] m_pending;
  logic [31:0] m_epc;
  logic [31:0] m_efg;
  int m_count;
  logic [31:0] last_word; // replay copy
  logic stalled_last;
  int replay_left;
  fields_t e_f;
  logic [31:0] e_pc;
  logic [31:0] e_d1;
  logic [31:0] e_d2;
  logic e_bubble;
  logic [7:0] e_exc;

  integer seed = 14578;
  string cur_test;

  decode_stage #(.TIMER_PERIOD(PERIOD)) decode_stage_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int rnd(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $random(seed);
    if (w[31:27] == 5'd15 && w[12]) w[7:0] = 8'h01; // legal syscall now and then
    return w;
  endfunction

  function automatic logic [3:0] top_line(input logic [15:0] lines);
    for (int i = 15; i >= 0; i--) begin
      if (lines[i]) return 4'(i);
    end
    return 4'd0;
  endfunction

  function automatic logic [31:0] creg_read(input logic [4:0] idx);
    case (idx)
      5'd0: return {31'b0, m_kmode};
      5'd1: return {20'b0, m_pid};
      5'd2: return {16'b0, m_enable};
      5'd3: return m_epc;
      5'd4: return m_efg;
      default: return 32'b0;
    endcase
  endfunction

  // read sees same-edge writes with port 2 over port 1
  function automatic logic [31:0] reg_read(input logic [4:0] idx);
    if (idx == 5'd0) return 32'b0;
    if (we2 && target_2 == idx) return write_data_2;
    if (we1 && target_1 == idx) return write_data_1;
    return m_regs[idx];
  endfunction

  function automatic fields_t decode_word(input logic [31:0] w, input logic km,
                                          input logic bub, input logic [7:0] tlb);
    fields_t d;
    logic [4:0] op;
    logic [4:0] sel;
    logic [4:0] aop;
    logic [4:0] ra;
    logic [4:0] rb;
    int form;
    logic mem;
    logic ld;
    logic drop_b;
    logic bad;
    d = '0;
    op = w[31:27];
    sel = w[16:12];
    aop = (op == 5'd0) ? w[9:5] : sel;
    ra = (op == 5'd13 || op == 5'd14) ? w[9:5] : w[26:22];
    rb = (op == 5'd13 || op == 5'd14) ? w[4:0] : w[21:17];
    mem = op >= 5'd3 && op <= 5'd11;
    form = mem ? (int'(op) - 3) % 3 : 3; // 0 scaled, 1 disp16, 2 disp21
    d.opcode = op;
    d.alu_op = aop;
    d.branch_code = w[26:22];
    d.priv_type = sel;
    d.crmov_mode = w[11:10];
    d.cr_s = rb;
    d.is_branch = op >= 5'd12 && op <= 5'd14;
    ld = (form == 2) ? w[21] : w[16];
    d.is_load = mem && ld;
    d.is_store = mem && !ld;
    drop_b = op == 5'd2 || form == 2 || op == 5'd12 || op == 5'd15 ||
             (op <= 5'd1 && aop == 5'd6);
    d.s_1 = drop_b ? 5'd0 : rb;
    if (d.is_store || op == 5'd31) d.s_2 = ra;
    else if (op == 5'd0) d.s_2 = w[4:0];
    d.tgt_1 = d.is_store ? 5'd0 : ra;
    if (form == 0 && w[15:14] != 2'd0) d.tgt_2 = rb; // base update
    d.is_post_inc = form == 0 && w[15:14] == 2'd2;
    case (op)
      5'd1: begin
        if (aop <= 5'd6) d.imm = 32'(w[7:0]) << (8 * w[9:8]);
        else if (aop <= 5'd13) d.imm = 32'(w[4:0]);
        else if (aop <= 5'd18) d.imm = {{20{w[11]}}, w[11:0]};
      end
      5'd2: d.imm = {w[21:0], 10'b0};
      5'd12: d.imm = {{10{w[21]}}, w[21:0]};
      default: begin
        if (form == 0) d.imm = {{20{w[11]}}, w[11:0]} << w[13:12];
        else if (form == 1) d.imm = {{16{w[15]}}, w[15:0]};
        else if (form == 2) d.imm = {{11{w[20]}}, w[20:0]};
      end
    endcase
    if (op == 5'd31) begin
      d.tgts_cr = sel == 5'd1 && (w[11:10] == 2'd0 || w[11:10] == 2'd2);
      d.tlb_we = sel == 5'd0 && w[11:10] == 2'd1;
      d.tlbc = sel == 5'd0 && w[11:10] == 2'd2;
    end
    bad = (op >= 5'd16 && op <= 5'd30) || (op <= 5'd1 && aop > 5'd18) ||
          (d.is_branch && w[26:22] > 5'd18) || (op == 5'd15 && w[7:0] != 8'h01) ||
          (op == 5'd31 && sel > 5'd3);
    if (bub) d.fault = 8'h00;
    else if (bad) d.fault = 8'h80;
    else if (op == 5'd31 && !km) d.fault = 8'h81;
    else if (op == 5'd15) d.fault = w[7:0];
    else d.fault = tlb;
    return d;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch in %s test, %s: expected %h, actual %h",
               cur_test, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout in %s test: %s", cur_test, what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic check_reset_state();
    check_value("bubble_out", 32'd1, bubble_out);
    check_value("tgt_out_1", 32'd0, tgt_out_1);
    check_value("tgt_out_2", 32'd0, tgt_out_2);
    check_value("exc_out", 32'd0, exc_out);
    check_value("tlb_we", 32'd0, tlb_we);
    check_value("tlbc", 32'd0, tlbc);
    check_value("kmode", 32'd1, kmode);
    check_value("pid", 32'd0, pid);
    check_value("d_1", 32'd0, d_1);
    check_value("d_2", 32'd0, d_2);
  endtask

  task automatic reset_model();
    for (int i = 0; i < 32; i++) m_regs[i] = 32'b0;
    m_kmode = 1'b1;
    m_pid = '0;
    m_enable = '0;
    m_pending = '0;
    m_epc = '0;
    m_efg = '0;
    m_count = PERIOD - 1;
    last_word = '0;
    stalled_last = 1'b0;
    replay_left = 0;
    e_f = '0;
    e_pc = '0;
    e_d1 = '0;
    e_d2 = '0;
    e_bubble = 1'b1;
    e_exc = 8'h00;
  endtask

  // predicts one rising edge from the inputs now on the pins
  task automatic model_edge();
    logic [31:0] w;
    logic tick_now;
    logic [15:0] istate;
    logic [15:0] taken;
    fields_t f;
    if (halt) return; // a halted edge changes nothing
    w = (stalled_last || replay_left != 0) ? last_word : mem_word;
    if (!(stall && stalled_last)) last_word = mem_word;
    if (stall) replay_left = 0;
    else if (stalled_last) replay_left = 2;
    else if (replay_left != 0) replay_left--;
    stalled_last = stall;
    f = decode_word(w, m_kmode, bubble_in, tlb_exc_in);
    istate = m_kmode ? 16'h0000 : (m_pending & m_enable);
    if (!stall) begin
      e_d1 = reg_read(f.s_1);
      e_d2 = reg_read(f.s_2);
      e_pc = pc_in;
      e_bubble = flush || bubble_in;
      if (istate != 16'h0000) e_exc = {4'hF, top_line(istate)};
      else if (exc_in != 8'h00) e_exc = exc_in;
      else e_exc = f.fault;
      if (flush || bubble_in) begin
        f.tgt_1 = 5'd0;
        f.tgt_2 = 5'd0;
      end
      e_f = f;
    end
    if (we1 && target_1 != 5'd0) m_regs[target_1] = write_data_1;
    if (we2 && target_2 != 5'd0) m_regs[target_2] = write_data_2;
    tick_now = m_count == 0;
    taken = interrupt_in_wb ? (16'h0001 << top_line(m_pending & m_enable)) : 16'h0000;
    m_pending = (m_pending & ~taken) | {irq, tick_now};
    if (cr_we) begin
      case (target_1)
        5'd0: m_kmode = write_data_1[0];
        5'd1: m_pid = write_data_1[11:0];
        5'd2: m_enable = write_data_1[15:0];
        5'd3: m_epc = write_data_1;
        5'd4: m_efg = write_data_1;
        default: ;
      endcase
    end
    if (rfe_in_wb) m_kmode = 1'b0;
    if (exc_in_wb) begin
      m_epc = epc;
      m_efg = efg;
      m_kmode = 1'b1;
    end
    m_count = tick_now ? PERIOD - 1 : m_count - 1;
  endtask

  task automatic compare_outputs();
    check_value("pc_out", e_pc, pc_out);
    check_value("opcode_out", e_f.opcode, opcode_out);
    check_value("alu_op_out", e_f.alu_op, alu_op_out);
    check_value("branch_code_out", e_f.branch_code, branch_code_out);
    check_value("priv_type_out", e_f.priv_type, priv_type_out);
    check_value("crmov_mode_out", e_f.crmov_mode, crmov_mode_out);
    check_value("s_1_out", e_f.s_1, s_1_out);
    check_value("s_2_out", e_f.s_2, s_2_out);
    check_value("cr_s_out", e_f.cr_s, cr_s_out);
    check_value("tgt_out_1", e_f.tgt_1, tgt_out_1);
    check_value("tgt_out_2", e_f.tgt_2, tgt_out_2);
    check_value("imm_out", e_f.imm, imm_out);
    check_value("is_load_out", e_f.is_load, is_load_out);
    check_value("is_store_out", e_f.is_store, is_store_out);
    check_value("is_branch_out", e_f.is_branch, is_branch_out);
    check_value("is_post_inc_out", e_f.is_post_inc, is_post_inc_out);
    check_value("tgts_cr_out", e_f.tgts_cr, tgts_cr_out);
    check_value("tlb_we", e_f.tlb_we, tlb_we);
    check_value("tlbc", e_f.tlbc, tlbc);
    check_value("bubble_out", e_bubble, bubble_out);
    check_value("exc_out", e_exc, exc_out);
    check_value("d_1", e_d1, d_1);
    check_value("d_2", e_d2, d_2);
    check_value("cr_d", creg_read(e_f.cr_s), cr_d); // follows cr_s_out
    check_value("kmode", m_kmode, kmode);
    check_value("pid", m_pid, pid);
  endtask

  task automatic step();
    model_edge();
    @(posedge clk);
    #5;
    compare_outputs();
  endtask

  task automatic quiet_inputs();
    halt = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    bubble_in = 1'b0;
    exc_in = 8'h00;
    tlb_exc_in = 8'h00;
    we1 = 1'b0;
    we2 = 1'b0;
    cr_we = 1'b0;
    exc_in_wb = 1'b0;
    rfe_in_wb = 1'b0;
    interrupt_in_wb = 1'b0;
    irq = '0;
  endtask

  task automatic write_creg(input logic [4:0] idx, input logic [31:0] data);
    cr_we = 1'b1;
    target_1 = idx;
    write_data_1 = data;
    step();
    cr_we = 1'b0;
  endtask

  initial begin
    int burst;
    int waited;
    rst = 1'b1;
    quiet_inputs();
    mem_word = '0;
    pc_in = '0;
    target_1 = '0;
    target_2 = '0;
    write_data_1 = '0;
    write_data_2 = '0;
    epc = '0;
    efg = '0;
    repeat (3) @(posedge clk);
    #5;
    cur_test = "reset";
    check_reset_state();
    rst = 1'b0;
    reset_model();

    cur_test = "decode";
    write_creg(5'd0, 32'd0); // user mode with the enable mask still clear
    for (int n = 0; n < 2000; n++) begin
      mem_word = random_word();
      pc_in = $random(seed);
      tlb_exc_in = (rnd(4) == 0) ? 8'(rnd(256)) : 8'h00;
      step();
    end

    cur_test = "regfile";
    for (int n = 0; n < 600; n++) begin
      mem_word = random_word();
      pc_in = $random(seed);
      we1 = rnd(2) == 0;
      we2 = rnd(2) == 0;
      cr_we = rnd(4) == 0;
      target_1 = (rnd(2) == 0) ? mem_word[21:17] : 5'(rnd(32)); // hit the read port often
      target_2 = (rnd(3) == 0) ? target_1 : 5'(rnd(32));
      write_data_1 = $random(seed);
      write_data_2 = $random(seed);
      halt = rnd(8) == 0; // writes must not land while halted
      step();
    end

    cur_test = "stall";
    quiet_inputs();
    burst = 0;
    for (int n = 0; n < 600; n++) begin
      mem_word = random_word();
      pc_in = $random(seed);
      if (burst > 0) begin
        stall = 1'b1;
        burst--;
      end else if (rnd(6) == 0) begin
        stall = 1'b1;
        burst = rnd(4);
      end else begin
        stall = 1'b0;
      end
      step();
    end

    cur_test = "bubble";
    quiet_inputs();
    for (int n = 0; n < 400; n++) begin
      mem_word = random_word();
      pc_in = $random(seed);
      flush = rnd(3) == 0;
      bubble_in = rnd(3) == 0;
      exc_in = (rnd(4) == 0) ? 8'(rnd(256)) : 8'h00;
      tlb_exc_in = (rnd(4) == 0) ? 8'(rnd(256)) : 8'h00;
      step();
    end

    cur_test = "interrupt";
    quiet_inputs();
    write_creg(5'd0, 32'd0);
    write_creg(5'd2, 32'd1); // timer line only
    waited = 0;
    while (exc_out < 8'hF0 && waited < 3 * PERIOD) begin
      mem_word = random_word();
      step();
      waited++;
    end
    if (exc_out < 8'hF0) fail_timeout("timer interrupt never reported");
    for (int n = 0; n < 300; n++) begin
      mem_word = random_word();
      irq = 15'($random(seed) & $random(seed) & $random(seed));
      interrupt_in_wb = rnd(3) == 0;
      cr_we = rnd(10) == 0;
      target_1 = 5'd2;
      write_data_1 = $random(seed);
      exc_in = (rnd(4) == 0) ? 8'(rnd(128)) : 8'h00;
      step();
    end

    // exception entry puts the core in kernel mode
    quiet_inputs();
    write_creg(5'd2, 32'h0000_FFFF);
    epc = $random(seed);
    efg = $random(seed);
    exc_in_wb = 1'b1;
    step();
    exc_in_wb = 1'b0;
    for (int n = 0; n < 20; n++) begin
      mem_word = random_word();
      irq = 15'($random(seed));
      step();
      check_value("irq hidden in kernel mode", 32'd0, 32'(exc_out >= 8'hF0));
    end
    rfe_in_wb = 1'b1;
    step();
    rfe_in_wb = 1'b0;
    irq = 15'h7FFF;
    waited = 0;
    while (exc_out < 8'hF0 && waited < 10) begin
      mem_word = random_word();
      step();
      waited++;
    end
    if (exc_out < 8'hF0) fail_timeout("interrupts not reported after rfe");
    check_value("highest line after rfe", 32'h0000_00FF, exc_out);

    $display("NO ERRORS");
    $finish;
  end

endmodule
